//--- common/lsu_pkg.sv
package lsu_pkg;

    // data and address width
    localparam int XLEN = 32;

    // reorder-buffer tag width
    localparam int TAG_W = 3;

    // load-store buffer entries, also the issue credit count
    localparam int LSB_DEPTH = 8;
    localparam int LSB_IDX_W = $clog2(LSB_DEPTH);

    // fetch address queue slots, also the fetch credit count
    localparam int FQ_DEPTH = 8;
    localparam int FQ_PTR_W = $clog2(FQ_DEPTH);

    // bytes per instruction word
    localparam int FETCH_BYTES = 4;

    // memory op codes, same encoding as the core's op field
    typedef enum logic [4:0] {
        LB  = 5'b10010,
        LH  = 5'b10011,
        LW  = 5'b10100,
        LBU = 5'b10101,
        LHU = 5'b10110,
        SB  = 5'b10111,
        SH  = 5'b11000,
        SW  = 5'b11001
    } mem_op_e;

    // access size
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } width_e;

endpackage

//--- common/mem_op_if.sv
`timescale 1ns/1ps

interface mem_op_if;

    logic                     op_valid;
    logic [lsu_pkg::TAG_W-1:0] tag;
    lsu_pkg::width_e          width;
    logic                     is_signed;
    logic                     is_store;
    logic [lsu_pkg::XLEN-1:0] addr;
    logic [lsu_pkg::XLEN-1:0] data;
    logic                     op_take;

    // entry table side
    modport decode (
        output op_valid, tag, width, is_signed, is_store, addr, data,
        input  op_take
    );

    // memory engine side
    modport execute (
        input  op_valid, tag, width, is_signed, is_store, addr, data,
        output op_take
    );

endinterface

//--- common/mem_result_if.sv
`timescale 1ns/1ps

interface mem_result_if;

    logic                      res_valid;
    logic [lsu_pkg::TAG_W-1:0] tag;
    lsu_pkg::width_e           width;
    logic                      is_signed;
    logic                      is_store;
    logic [lsu_pkg::XLEN-1:0]  raw;

    modport source (output res_valid, tag, width, is_signed, is_store, raw);

    modport sink (input res_valid, tag, width, is_signed, is_store, raw);

    // only completion and tag, for freeing entries
    modport monitor (input res_valid, tag);

endinterface

//--- design/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     fetch_valid,
    input  logic [lsu_pkg::XLEN-1:0] fetch_pc,
    input  logic                     fq_pop,
    output logic                     fq_valid,
    output logic [lsu_pkg::XLEN-1:0] fq_pc,
    output logic                     fetch_credit
);

    logic [lsu_pkg::XLEN-1:0]     pc_mem [lsu_pkg::FQ_DEPTH];
    logic [lsu_pkg::FQ_PTR_W-1:0] head;
    logic [lsu_pkg::FQ_PTR_W-1:0] tail;
    logic [lsu_pkg::FQ_PTR_W:0]   count;

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            pc_mem[tail] <= fetch_pc;
        end
    end

    // credits keep the fetch unit from overrunning the queue
    always_ff @(posedge clk) begin
        if (!rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            fetch_credit <= 1'b0;
        end else begin
            if (fetch_valid) begin
                tail <= tail + 1'b1;
            end
            if (fq_pop) begin
                head <= head + 1'b1;
            end
            count        <= count + (fetch_valid ? 1'b1 : 1'b0) - (fq_pop ? 1'b1 : 1'b0);
            fetch_credit <= fq_pop;
        end
    end

    assign fq_valid = (count != '0);
    assign fq_pc    = pc_mem[head];

endmodule

//--- design/load_formatter.sv
`timescale 1ns/1ps

module load_formatter (
    input  logic                      clk,
    input  logic                      rst,
    mem_result_if.sink                res,
    output logic                      done_valid,
    output logic [lsu_pkg::TAG_W-1:0] done_tag,
    output logic [lsu_pkg::XLEN-1:0]  done_value,
    output logic                      done_is_store
);

    logic [lsu_pkg::XLEN-1:0] ext_value;

    always_comb begin
        if (res.is_store) begin
            ext_value = '0;
        end else begin
            case (res.width)
                lsu_pkg::BYTE: ext_value = {{24{res.is_signed & res.raw[7]}}, res.raw[7:0]};
                lsu_pkg::HALF: ext_value = {{16{res.is_signed & res.raw[15]}}, res.raw[15:0]};
                default:       ext_value = res.raw;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            done_valid <= 1'b0;
        end else begin
            done_valid <= res.res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res.res_valid) begin
            done_tag      <= res.tag;
            done_value    <= ext_value;
            done_is_store <= res.is_store;
        end
    end

endmodule

//--- design/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  logic [lsu_pkg::TAG_W-1:0] issue_tag,
    input  lsu_pkg::mem_op_e          issue_op,
    input  logic [lsu_pkg::XLEN-1:0]  issue_addr,
    input  logic [lsu_pkg::XLEN-1:0]  issue_data,
    output logic                      issue_credit,
    input  logic                      commit_valid,
    input  logic [lsu_pkg::TAG_W-1:0] commit_tag,
    input  logic                      fetch_valid,
    input  logic [lsu_pkg::XLEN-1:0]  fetch_pc,
    output logic                      fetch_credit,
    output logic                      ins_valid,
    output logic [lsu_pkg::XLEN-1:0]  ins_pc,
    output logic [lsu_pkg::XLEN-1:0]  ins_value,
    output logic                      done_valid,
    output logic [lsu_pkg::TAG_W-1:0] done_tag,
    output logic [lsu_pkg::XLEN-1:0]  done_value,
    output logic                      done_is_store,
    output logic [lsu_pkg::XLEN-1:0]  ram_addr,
    output logic                      ram_we,
    output logic [7:0]                ram_wdata,
    input  logic [7:0]                ram_rdata
);

    mem_op_if     op_bus ();
    mem_result_if res_bus ();

    logic                     fq_valid;
    logic [lsu_pkg::XLEN-1:0] fq_pc;
    logic                     fq_pop;

    lsb_entry_table u_entry_table (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_tag    (issue_tag),
        .issue_op     (issue_op),
        .issue_addr   (issue_addr),
        .issue_data   (issue_data),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .res          (res_bus.monitor),
        .op           (op_bus.decode),
        .issue_credit (issue_credit)
    );

    lsb_mem_engine u_mem_engine (
        .clk       (clk),
        .rst       (rst),
        .op        (op_bus.execute),
        .fq_valid  (fq_valid),
        .fq_pc     (fq_pc),
        .fq_pop    (fq_pop),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .res       (res_bus.source),
        .ins_valid (ins_valid),
        .ins_pc    (ins_pc),
        .ins_value (ins_value)
    );

    fetch_queue u_fetch_queue (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fq_pop       (fq_pop),
        .fq_valid     (fq_valid),
        .fq_pc        (fq_pc),
        .fetch_credit (fetch_credit)
    );

    load_formatter u_load_formatter (
        .clk           (clk),
        .rst           (rst),
        .res           (res_bus.sink),
        .done_valid    (done_valid),
        .done_tag      (done_tag),
        .done_value    (done_value),
        .done_is_store (done_is_store)
    );

endmodule

//--- lsb/lsb_entry_table.sv
`timescale 1ns/1ps

module lsb_entry_table (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  logic [lsu_pkg::TAG_W-1:0] issue_tag,
    input  lsu_pkg::mem_op_e          issue_op,
    input  logic [lsu_pkg::XLEN-1:0]  issue_addr,
    input  logic [lsu_pkg::XLEN-1:0]  issue_data,
    input  logic                      commit_valid,
    input  logic [lsu_pkg::TAG_W-1:0] commit_tag,
    mem_result_if.monitor             res,
    mem_op_if.decode                  op,
    output logic                      issue_credit
);

    logic                      ent_live   [lsu_pkg::LSB_DEPTH];
    lsu_pkg::width_e           ent_width  [lsu_pkg::LSB_DEPTH];
    logic                      ent_signed [lsu_pkg::LSB_DEPTH];
    logic                      ent_store  [lsu_pkg::LSB_DEPTH];
    logic [lsu_pkg::XLEN-1:0]  ent_addr   [lsu_pkg::LSB_DEPTH];
    logic [lsu_pkg::XLEN-1:0]  ent_data   [lsu_pkg::LSB_DEPTH];

    logic [lsu_pkg::TAG_W-1:0]   cq_tags [lsu_pkg::LSB_DEPTH];
    logic [lsu_pkg::LSB_IDX_W-1:0] cq_head;
    logic [lsu_pkg::LSB_IDX_W-1:0] cq_tail;
    logic [lsu_pkg::LSB_IDX_W:0]   cq_count;
    logic [lsu_pkg::TAG_W-1:0]     head_tag;

    lsu_pkg::width_e dec_width;
    logic            dec_signed;
    logic            dec_store;

    // width, sign and direction all follow from the op code
    always_comb begin
        dec_width  = lsu_pkg::BYTE;
        dec_signed = 1'b0;
        dec_store  = 1'b0;
        case (issue_op)
            lsu_pkg::LB:  dec_signed = 1'b1;
            lsu_pkg::LH: begin
                dec_width  = lsu_pkg::HALF;
                dec_signed = 1'b1;
            end
            lsu_pkg::LW:  dec_width = lsu_pkg::WORD;
            lsu_pkg::LBU: dec_width = lsu_pkg::BYTE;
            lsu_pkg::LHU: dec_width = lsu_pkg::HALF;
            lsu_pkg::SB:  dec_store = 1'b1;
            lsu_pkg::SH: begin
                dec_width = lsu_pkg::HALF;
                dec_store = 1'b1;
            end
            lsu_pkg::SW: begin
                dec_width = lsu_pkg::WORD;
                dec_store = 1'b1;
            end
            default: dec_width = lsu_pkg::BYTE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            ent_width[issue_tag]  <= dec_width;
            ent_signed[issue_tag] <= dec_signed;
            ent_store[issue_tag]  <= dec_store;
            ent_addr[issue_tag]   <= issue_addr;
            ent_data[issue_tag]   <= issue_data;
        end
        if (commit_valid) begin
            cq_tags[cq_tail] <= commit_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < lsu_pkg::LSB_DEPTH; i++) begin
                ent_live[i] <= 1'b0;
            end
            cq_head      <= '0;
            cq_tail      <= '0;
            cq_count     <= '0;
            issue_credit <= 1'b0;
        end else begin
            // free first so a same-cycle reissue of the tag wins
            if (res.res_valid) begin
                ent_live[res.tag] <= 1'b0;
            end
            if (issue_valid) begin
                ent_live[issue_tag] <= 1'b1;
            end
            // credit lines up with done_valid from the formatter
            issue_credit <= res.res_valid;
            if (commit_valid) begin
                cq_tail <= cq_tail + 1'b1;
            end
            if (op.op_take) begin
                cq_head <= cq_head + 1'b1;
            end
            cq_count <= cq_count + (commit_valid ? 1'b1 : 1'b0) - (op.op_take ? 1'b1 : 1'b0);
        end
    end

    assign head_tag = cq_tags[cq_head];

    assign op.op_valid  = (cq_count != '0) && ent_live[head_tag];
    assign op.tag       = head_tag;
    assign op.width     = ent_width[head_tag];
    assign op.is_signed = ent_signed[head_tag];
    assign op.is_store  = ent_store[head_tag];
    assign op.addr      = ent_addr[head_tag];
    assign op.data      = ent_data[head_tag];

endmodule

//--- lsb/lsb_mem_engine.sv
`timescale 1ns/1ps

module lsb_mem_engine (
    input  logic                      clk,
    input  logic                      rst,
    mem_op_if.execute                 op,
    input  logic                      fq_valid,
    input  logic [lsu_pkg::XLEN-1:0]  fq_pc,
    output logic                      fq_pop,
    output logic [lsu_pkg::XLEN-1:0]  ram_addr,
    output logic                      ram_we,
    output logic [7:0]                ram_wdata,
    input  logic [7:0]                ram_rdata,
    mem_result_if.source              res,
    output logic                      ins_valid,
    output logic [lsu_pkg::XLEN-1:0]  ins_pc,
    output logic [lsu_pkg::XLEN-1:0]  ins_value
);

    logic       busy;
    logic [2:0] cnt;
    logic       res_pulse;
    logic       ins_pulse;

    logic                      cur_fetch;
    logic                      cur_store;
    logic                      cur_signed;
    lsu_pkg::width_e           cur_width;
    logic [lsu_pkg::TAG_W-1:0] cur_tag;
    logic [lsu_pkg::XLEN-1:0]  cur_addr;
    logic [lsu_pkg::XLEN-1:0]  cur_data;
    logic [2:0]                cur_n;
    logic [lsu_pkg::XLEN-1:0]  raw_q;

    logic       start_op;
    logic       start_fetch;
    logic       last_cycle;
    logic [1:0] cap_idx;
    logic [2:0] op_bytes;

    // committed op beats a waiting fetch
    assign start_op    = !busy && op.op_valid;
    assign start_fetch = !busy && !op.op_valid && fq_valid;
    assign op.op_take  = start_op;

    always_comb begin
        case (op.width)
            lsu_pkg::HALF: op_bytes = 3'd2;
            lsu_pkg::WORD: op_bytes = 3'd4;
            default:       op_bytes = 3'd1;
        endcase
    end

    // stores end on the last write, reads on the last capture
    assign last_cycle = cur_store ? (cnt == cur_n - 3'd1) : (cnt == cur_n);

    // read data lags the address by one cycle
    assign cap_idx = cnt[1:0] - 2'd1;

    assign fq_pop = busy && cur_fetch && last_cycle;

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy      <= 1'b0;
            cnt       <= '0;
            res_pulse <= 1'b0;
            ins_pulse <= 1'b0;
        end else begin
            res_pulse <= 1'b0;
            ins_pulse <= 1'b0;
            if (!busy) begin
                cnt <= '0;
                if (start_op || start_fetch) begin
                    busy <= 1'b1;
                end
            end else begin
                cnt <= cnt + 3'd1;
                if (last_cycle) begin
                    busy      <= 1'b0;
                    ins_pulse <= cur_fetch;
                    res_pulse <= !cur_fetch;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_op) begin
            cur_fetch  <= 1'b0;
            cur_store  <= op.is_store;
            cur_signed <= op.is_signed;
            cur_width  <= op.width;
            cur_tag    <= op.tag;
            cur_addr   <= op.addr;
            cur_data   <= op.data;
            cur_n      <= op_bytes;
            raw_q      <= '0;
        end else if (start_fetch) begin
            cur_fetch <= 1'b1;
            cur_store <= 1'b0;
            cur_width <= lsu_pkg::WORD;
            cur_addr  <= fq_pc;
            cur_n     <= 3'(lsu_pkg::FETCH_BYTES);
            raw_q     <= '0;
        end else if (busy && !cur_store && cnt != 3'd0) begin
            raw_q[8*cap_idx +: 8] <= ram_rdata;
        end
    end

    assign ram_addr  = cur_addr + lsu_pkg::XLEN'(cnt);
    assign ram_we    = busy && cur_store && (cnt < cur_n);
    assign ram_wdata = cur_data[8*cnt[1:0] +: 8];

    assign res.res_valid = res_pulse;
    assign res.tag       = cur_tag;
    assign res.width     = cur_width;
    assign res.is_signed = cur_signed;
    assign res.is_store  = cur_store;
    assign res.raw       = raw_q;

    assign ins_valid = ins_pulse;
    assign ins_pc    = cur_addr;
    assign ins_value = raw_q;

endmodule

//--- run.sh
#!/bin/sh
# build and run the mem_subsys testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsys -f sources.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "pass message not found"
exit 1

//--- sources.f
common/lsu_pkg.sv
common/mem_op_if.sv
common/mem_result_if.sv
lsb/lsb_entry_table.sv
lsb/lsb_mem_engine.sv
design/fetch_queue.sv
design/load_formatter.sv
design/mem_subsys.sv
test/tb_byte_ram.sv
test/tb_mem_subsys.sv

//--- test/tb_byte_ram.sv
`timescale 1ns/1ps

module tb_byte_ram #(
    parameter int ADDR_W = 10
) (
    input  logic        clk,
    input  logic [31:0] addr,
    input  logic        we,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata
);

    logic [7:0] mem [2**ADDR_W];

    initial begin
        rdata = 8'h00;
        // pattern mixes every address bit
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = 8'((i * 37) ^ (i >> 5) ^ 8'h3c);
        end
    end

    // one-cycle read, old data on a same-cycle write
    always @(posedge clk) begin
        if (we) begin
            mem[addr[ADDR_W-1:0]] <= wdata;
        end
        rdata <= mem[addr[ADDR_W-1:0]];
    end

endmodule

//--- test/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int PERIOD = 40;
    localparam int RAM_BYTES = 1024;
    localparam int N_OPS = 48;
    localparam int N_FETCH = 24;
    // per item, counting idle gaps of the random driver
    localparam int WORST_CYCLES = 32;
    localparam int WATCHDOG_NS = ((N_OPS + N_FETCH) * WORST_CYCLES + 64) * PERIOD;

    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  data;
    } wr_t;

    typedef struct packed {
        logic [2:0]  tag;
        logic        is_store;
        logic [31:0] value;
    } done_t;

    typedef struct packed {
        logic [2:0]       tag;
        lsu_pkg::mem_op_e op;
        logic [31:0]      addr;
        logic [31:0]      data;
    } pend_t;

    logic clk;
    logic rst;
    logic issue_valid;
    logic [2:0] issue_tag;
    lsu_pkg::mem_op_e issue_op;
    logic [31:0] issue_addr;
    logic [31:0] issue_data;
    logic issue_credit;
    logic commit_valid;
    logic [2:0] commit_tag;
    logic fetch_valid;
    logic [31:0] fetch_pc;
    logic fetch_credit;
    logic ins_valid;
    logic [31:0] ins_pc;
    logic [31:0] ins_value;
    logic done_valid;
    logic [2:0] done_tag;
    logic [31:0] done_value;
    logic done_is_store;
    logic [31:0] ram_addr;
    logic ram_we;
    logic [7:0] ram_wdata;
    logic [7:0] ram_rdata;

    logic [7:0] ref_mem [RAM_BYTES];
    logic tag_busy [lsu_pkg::LSB_DEPTH];
    logic [31:0] seed = 32'h0d50faa9;
    logic reset_window;
    int issued_n = 0;
    int icredit_n = 0;
    int fetched_n = 0;
    int fcredit_n = 0;
    pend_t pend_q [$];
    done_t exp_done_q [$];
    wr_t exp_wr_q [$];
    logic [31:0] exp_pc_q [$];

    mem_subsys dut0 (.*);

    tb_byte_ram ram0 (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before all operations completed");
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int op_size(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic lsu_pkg::mem_op_e op_from_index(input logic [2:0] k);
        case (k)
            3'd0: return lsu_pkg::LB;
            3'd1: return lsu_pkg::LH;
            3'd2: return lsu_pkg::LW;
            3'd3: return lsu_pkg::LBU;
            3'd4: return lsu_pkg::LHU;
            3'd5: return lsu_pkg::SB;
            3'd6: return lsu_pkg::SH;
            default: return lsu_pkg::SW;
        endcase
    endfunction

    task automatic quiet_inputs();
        issue_valid = 1'b0;
        issue_tag = '0;
        issue_op = lsu_pkg::LB;
        issue_addr = '0;
        issue_data = '0;
        commit_valid = 1'b0;
        commit_tag = '0;
        fetch_valid = 1'b0;
        fetch_pc = '0;
    endtask

    task automatic start_issue(input int tag, input lsu_pkg::mem_op_e op,
                               input logic [31:0] addr, input logic [31:0] data);
        issue_valid = 1'b1;
        issue_tag = 3'(tag);
        issue_op = op;
        issue_addr = addr;
        issue_data = data;
        tag_busy[tag] = 1'b1;
        issued_n++;
        pend_q.push_back('{tag: 3'(tag), op: op, addr: addr, data: data});
    endtask

    task automatic start_fetch(input logic [31:0] pc);
        fetch_valid = 1'b1;
        fetch_pc = pc;
        fetched_n++;
        exp_pc_q.push_back(pc);
    endtask

    // program order commit, reference memory follows the same order
    task automatic start_commit();
        pend_t p;
        logic [31:0] w;
        logic [31:0] v;
        int n;
        p = pend_q.pop_front();
        n = op_size(p.op);
        commit_valid = 1'b1;
        commit_tag = p.tag;
        w = '0;
        if (p.op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW}) begin
            for (int i = 0; i < n; i++) begin
                ref_mem[32'(p.addr + i)] = p.data[8*i +: 8];
                exp_wr_q.push_back('{addr: 32'(p.addr + i), data: p.data[8*i +: 8]});
            end
            exp_done_q.push_back('{tag: p.tag, is_store: 1'b1, value: 32'h0});
        end else begin
            for (int i = 0; i < n; i++) begin
                w[8*i +: 8] = ref_mem[32'(p.addr + i)];
            end
            case (p.op)
                lsu_pkg::LB: v = {{24{w[7]}}, w[7:0]};
                lsu_pkg::LH: v = {{16{w[15]}}, w[15:0]};
                default:     v = w;
            endcase
            exp_done_q.push_back('{tag: p.tag, is_store: 1'b0, value: v});
        end
    endtask

    task automatic check_write();
        wr_t e;
        assert (exp_wr_q.size() != 0)
            else abort_run("RAM write while no committed store was pending");
        e = exp_wr_q.pop_front();
        assert (ram_addr == e.addr)
            else abort_run($sformatf("ERR ram_addr got %h exp %h", ram_addr, e.addr));
        assert (ram_wdata == e.data)
            else abort_run($sformatf("ERR ram_wdata got %h exp %h", ram_wdata, e.data));
    endtask

    task automatic check_fetch();
        logic [31:0] pc;
        logic [31:0] w;
        assert (exp_pc_q.size() != 0)
            else abort_run("instruction delivered with no fetch pending");
        pc = exp_pc_q.pop_front();
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = ref_mem[32'(pc + i)];
        end
        assert (ins_pc == pc)
            else abort_run($sformatf("ERR ins_pc got %h exp %h", ins_pc, pc));
        assert (ins_value == w)
            else abort_run($sformatf("ERR ins_value got %h exp %h", ins_value, w));
    endtask

    task automatic check_done();
        done_t e;
        assert (exp_done_q.size() != 0)
            else abort_run("completion seen with no committed operation");
        e = exp_done_q.pop_front();
        assert (done_tag == e.tag)
            else abort_run($sformatf("ERR done_tag got %h exp %h", done_tag, e.tag));
        assert (done_is_store == e.is_store)
            else abort_run($sformatf("ERR done_is_store got %h exp %h", done_is_store, e.is_store));
        assert (done_value == e.value)
            else abort_run($sformatf("ERR done_value got %h exp %h", done_value, e.value));
        tag_busy[done_tag] = 1'b0;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            if (ram_we) check_write();
            if (ins_valid) check_fetch();
            if (done_valid) check_done();
            if (issue_credit) icredit_n++;
            if (fetch_credit) fcredit_n++;
        end
    end

    assert property (@(posedge clk) reset_window |->
                     !ram_we && !ins_valid && !done_valid && !issue_credit && !fetch_credit)
        else abort_run("an output was active during or right after reset");
    assert property (@(posedge clk) disable iff (!rst) done_valid == issue_credit)
        else abort_run($sformatf("ERR issue_credit %h done_valid %h", issue_credit, done_valid));
    assert property (@(posedge clk) disable iff (!rst) fetch_credit == ins_valid)
        else abort_run($sformatf("ERR fetch_credit %h ins_valid %h", fetch_credit, ins_valid));
    assert property (@(posedge clk) icredit_n <= issued_n)
        else abort_run("more issue credits returned than were spent");
    assert property (@(posedge clk) fcredit_n <= fetched_n)
        else abort_run("more fetch credits returned than were spent");

    initial begin
        logic [31:0] r;
        int tag;
        int ops_left;
        int fetch_left;
        rst = 1'b0;
        reset_window = 1'b0;
        quiet_inputs();
        for (int i = 0; i < lsu_pkg::LSB_DEPTH; i++) begin
            tag_busy[i] = 1'b0;
        end
        @(negedge clk);
        reset_window = 1'b1;
        for (int i = 0; i < RAM_BYTES; i++) begin
            ref_mem[i] = ram0.mem[i];
        end
        repeat (3) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        reset_window = 1'b0;

        // store sits uncommitted, no write may reach the RAM
        start_issue(5, lsu_pkg::SW, 32'h40, 32'hcafe_f00d);
        @(negedge clk);
        quiet_inputs();
        repeat (20) @(negedge clk);
        start_commit();
        @(negedge clk);

        ops_left = N_OPS;
        fetch_left = N_FETCH;
        while (ops_left > 0 || fetch_left > 0 || pend_q.size() != 0) begin
            quiet_inputs();
            r = lcg_next();
            if (pend_q.size() != 0 && r[0]) start_commit();
            if (ops_left > 0 && r[1] && issued_n - icredit_n < lsu_pkg::LSB_DEPTH) begin
                tag = int'(r[7:5]);
                while (tag_busy[tag]) tag = (tag + 1) % lsu_pkg::LSB_DEPTH;
                start_issue(tag, op_from_index(r[10:8]), lcg_next() % 32'h1fc, lcg_next());
                ops_left--;
            end
            if (fetch_left > 0 && r[2] && fetched_n - fcredit_n < lsu_pkg::FQ_DEPTH) begin
                start_fetch(32'h200 + {23'h0, r[17:11], 2'b00});
                fetch_left--;
            end
            @(negedge clk);
        end
        quiet_inputs();
        while (exp_done_q.size() != 0 || exp_pc_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);

        if (issued_n == icredit_n && fetched_n == fcredit_n && exp_wr_q.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else if (exp_wr_q.size() != 0) begin
            abort_run("a store completed without writing all of its bytes");
        end else begin
            abort_run($sformatf("ERR issue_credit count %h exp %h, fetch_credit count %h exp %h",
                                icredit_n, issued_n, fcredit_n, fetched_n));
        end
    end

endmodule
